// ==== verilog/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// register and operand width
`define XLEN 64

// instruction memory size in 32-bit words
`define IMEM_DEPTH 64

// word address width, log2 of IMEM_DEPTH
// byte pc is two bits wider
`define IMEM_AW 6

`endif

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  // I-type layout, used by addi and ebreak
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  // U-type layout, used by auipc
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  // one fetched word, viewed either way
  // opcode and rd sit at the same bits in both
  typedef union packed {
    rv_i_fmt_t i;
    rv_u_fmt_t u;
  } rv_inst_t;

  // op class handed from decode to control and execute
  typedef enum logic [1:0] {
    op_none    = 2'd0,
    op_add     = 2'd1,
    op_ebreak  = 2'd2,
    op_illegal = 2'd3
  } rv_op_e;

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

// ==== verilog/rv_imem.sv ====
`include "rv_core_cfg.svh"

module rv_imem
  import rv_pkg::*;
(
  input  logic                 clk,
  // load port, one word per strobe
  input  logic                 load_en,
  input  logic [`IMEM_AW-1:0]  load_addr,
  input  logic [31:0]          load_data,
  // byte address from the control unit
  input  logic [`IMEM_AW+1:0]  pc,
  output rv_inst_t             inst
);

  // program storage, one instruction word per entry
  logic [31:0] mem [`IMEM_DEPTH];

  // write side, driven by the testbench loader
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch is combinational, word index from pc[7:2]
  // index width wraps the fetch back to word 0
  assign inst = mem[pc[`IMEM_AW+1:2]];

  // fetch drops pc[1:0], so pc has to be word aligned
  pc_word_aligned: assert property (
    @(posedge clk) !$isunknown(pc) |-> (pc[1:0] == 2'b00)
  );

endmodule

// ==== verilog/rv_ctrl.sv ====
`include "rv_core_cfg.svh"

module rv_ctrl
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  // op class of the instruction in execute
  input  rv_op_e              op,
  // only watched by the load check below
  input  logic                load_en,
  output logic [`IMEM_AW+1:0] pc,
  output logic                run,
  output logic                halt,
  output logic                halt_illegal
);

  // run states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_RUN    = 2'd1;
  localparam logic [1:0] ST_HALTED = 2'd2;

  logic [1:0] state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      pc           <= '0;
      halt         <= 1'b0;
      halt_illegal <= 1'b0;
    end else begin
      // halt and its flag are one-cycle pulses
      halt         <= 1'b0;
      halt_illegal <= 1'b0;
      case (state)
        ST_IDLE, ST_HALTED: begin
          // start always fetches from word 0
          if (start) begin
            state <= ST_RUN;
            pc    <= '0;
          end
        end
        ST_RUN: begin
          if (op == op_ebreak || op == op_illegal) begin
            // stop, pc stays on the trapping word
            state        <= ST_HALTED;
            halt         <= 1'b1;
            halt_illegal <= (op == op_illegal);
          end else begin
            // one instruction per cycle, wraps at end of memory
            pc <= pc + 4;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign run = (state == ST_RUN);

  // imem may only be rewritten while the core is stopped
  no_load_while_run: assert property (
    @(posedge clk) disable iff (reset) load_en |-> !run
  );

  // one halt per start
  one_halt_per_start: assert property (
    @(posedge clk) disable iff (reset) halt |=> (!halt until start)
  );

endmodule

// ==== verilog/rv_idu.sv ====
`include "rv_core_cfg.svh"

module rv_idu
  import rv_pkg::*;
(
  input  logic                run,
  input  logic [`IMEM_AW+1:0] pc,
  input  rv_inst_t            inst,
  input  logic [`XLEN-1:0]    rs1_data,
  output rv_op_e              op,
  output logic [`XLEN-1:0]    op1,
  output logic [`XLEN-1:0]    op2,
  output logic [4:0]          rs1_addr,
  output logic                rd_w_en,
  output logic [4:0]          rd_w_addr
);

  logic             is_addi;
  logic             is_auipc;
  logic             is_ebreak;
  logic [`XLEN-1:0] imm_i_sext;
  logic [`XLEN-1:0] imm_u_sext;
  logic [`XLEN-1:0] pc_ext;

  // addi: OP-IMM with funct3 000
  assign is_addi   = (inst.i.opcode == OPC_OP_IMM) && (inst.i.funct3 == 3'b000);
  // auipc has no funct3, opcode alone
  assign is_auipc  = (inst.u.opcode == OPC_AUIPC);
  // ebreak: SYSTEM with funct3 000
  assign is_ebreak = (inst.i.opcode == OPC_SYSTEM) && (inst.i.funct3 == 3'b000);

  // 12-bit I immediate, sign extended
  assign imm_i_sext = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  // U immediate sits in bits 31:12, then sign extended from bit 31
  assign imm_u_sext = {{(`XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};

  // pc is short, zero extend for the adder
  assign pc_ext = {{(`XLEN-`IMEM_AW-2){1'b0}}, pc};

  always_comb begin
    op        = op_none;
    op1       = '0;
    op2       = '0;
    rs1_addr  = '0;
    rd_w_en   = 1'b0;
    rd_w_addr = '0;
    if (run) begin
      if (is_addi) begin
        // rs1 + imm
        op        = op_add;
        op1       = rs1_data;
        op2       = imm_i_sext;
        rs1_addr  = inst.i.rs1;
        rd_w_en   = 1'b1;
        rd_w_addr = inst.i.rd;
      end else if (is_auipc) begin
        // pc + (imm << 12)
        op        = op_add;
        op1       = pc_ext;
        op2       = imm_u_sext;
        rd_w_en   = 1'b1;
        rd_w_addr = inst.u.rd;
      end else if (is_ebreak) begin
        op = op_ebreak;
      end else begin
        // anything else traps
        op = op_illegal;
      end
    end
  end

endmodule

// ==== verilog/rv_regfile.sv ====
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             reset,
  // write port, fed by the retire register
  input  logic             w_en,
  input  logic [4:0]       w_addr,
  input  logic [`XLEN-1:0] w_data,
  // decode read port
  input  logic [4:0]       r_addr,
  output logic [`XLEN-1:0] r_data,
  // debug read port
  input  logic [4:0]       dbg_addr,
  output logic [`XLEN-1:0] dbg_data
);

  logic [`XLEN-1:0] regs [32];
  logic             fwd_hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && (w_addr != 5'd0)) begin
      // x0 is never written so it stays zero
      regs[w_addr] <= w_data;
    end
  end

  // retire of the previous instruction lands on this edge
  // so hand its data straight to the reader
  assign fwd_hit = w_en && (w_addr == r_addr) && (r_addr != 5'd0);

  assign r_data = fwd_hit ? w_data : regs[r_addr];

  // debug sees committed state only
  assign dbg_data = regs[dbg_addr];

endmodule

// ==== verilog/rv_exu.sv ====
`include "rv_core_cfg.svh"

module rv_exu
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  rv_op_e           op,
  input  logic [`XLEN-1:0] op1,
  input  logic [`XLEN-1:0] op2,
  input  logic             rd_w_en,
  input  logic [4:0]       rd_w_addr,
  // retire register, also the regfile write port
  output logic             retire,
  output logic [4:0]       retire_rd,
  output logic [`XLEN-1:0] retire_data
);

  logic [`XLEN-1:0] sum;
  logic             take;

  // addi and auipc both reduce to one add
  assign sum  = op1 + op2;
  assign take = (op == op_add) && rd_w_en;

  // retire strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      retire <= 1'b0;
    end else begin
      retire <= take;
    end
  end

  // payload, only loaded on a retiring op
  always_ff @(posedge clk) begin
    if (take) begin
      retire_rd <= rd_w_addr;
      // x0 reports 0, same as what the regfile holds
      retire_data <= (rd_w_addr == 5'd0) ? '0 : sum;
    end
  end

endmodule

// ==== verilog/rv_core.sv ====
`include "rv_core_cfg.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  // program load
  input  logic               load_en,
  input  logic [`IMEM_AW-1:0] load_addr,
  input  logic [31:0]        load_data,
  // run control
  input  logic               start,
  // retire report
  output logic               retire,
  output logic [4:0]         retire_rd,
  output logic [`XLEN-1:0]   retire_data,
  // stop report
  output logic               halt,
  output logic               halt_illegal,
  // debug register read
  input  logic [4:0]         dbg_addr,
  output logic [`XLEN-1:0]   dbg_data
);

  logic [`IMEM_AW+1:0] pc;
  logic                run;
  rv_inst_t            inst;
  rv_op_e              op;
  logic [4:0]          rs1_addr;
  logic [`XLEN-1:0]    rs1_data;
  logic [`XLEN-1:0]    op1;
  logic [`XLEN-1:0]    op2;
  logic                rd_w_en;
  logic [4:0]          rd_w_addr;

  // sequencing and pc
  rv_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .op           (op),
    .load_en      (load_en),
    .pc           (pc),
    .run          (run),
    .halt         (halt),
    .halt_illegal (halt_illegal)
  );

  // fetch
  rv_imem u_imem (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .inst      (inst)
  );

  // decode
  rv_idu u_idu (
    .run       (run),
    .pc        (pc),
    .inst      (inst),
    .rs1_data  (rs1_data),
    .op        (op),
    .op1       (op1),
    .op2       (op2),
    .rs1_addr  (rs1_addr),
    .rd_w_en   (rd_w_en),
    .rd_w_addr (rd_w_addr)
  );

  // register file, written from the retire register
  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .w_en     (retire),
    .w_addr   (retire_rd),
    .w_data   (retire_data),
    .r_addr   (rs1_addr),
    .r_data   (rs1_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  // execute and retire
  rv_exu u_exu (
    .clk         (clk),
    .reset       (reset),
    .op          (op),
    .op1         (op1),
    .op2         (op2),
    .rd_w_en     (rd_w_en),
    .rd_w_addr   (rd_w_addr),
    .retire      (retire),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

endmodule

// ==== sim/tb_rv_core.sv ====
`include "rv_core_cfg.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  // record kinds in the pattern file
  localparam logic [63:0] K_END    = 64'd0;
  localparam logic [63:0] K_LOAD   = 64'd1;
  localparam logic [63:0] K_START  = 64'd2;
  localparam logic [63:0] K_RETIRE = 64'd3;
  localparam logic [63:0] K_HALT   = 64'd4;
  localparam logic [63:0] K_DEBUG  = 64'd5;
  localparam int MAX_REC     = 128;
  localparam int CYC_PER_REC = 20;

  logic                clk;
  logic                reset;
  logic                load_en;
  logic [`IMEM_AW-1:0] load_addr;
  logic [31:0]         load_data;
  logic                start;
  logic                retire;
  logic [4:0]          retire_rd;
  logic [`XLEN-1:0]    retire_data;
  logic                halt;
  logic                halt_illegal;
  logic [4:0]          dbg_addr;
  logic [`XLEN-1:0]    dbg_data;

  // three words per record
  logic [63:0] pat [3*MAX_REC];

  // pulses still to come, oldest first
  logic [63:0] exp_kind [$];
  logic [63:0] exp_a [$];
  logic [63:0] exp_b [$];

  int   n_rec;
  int   cycles = 0;
  int   limit = 0;
  int   pulses = 0;
  logic halt_seen = 1'b0;

  // falling edges since the start strobe, and pulses of the current run
  int   since_start = 0;
  int   run_pulses = 0;

  rv_core DUT (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .retire       (retire),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halt         (halt),
    .halt_illegal (halt_illegal),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // run length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      stop_on_failure($sformatf("timeout, run not finished after %0d cycles", limit));
    end
  end

  // pulses checked in order at the falling edge
  always @(negedge clk) begin
    if (start) begin
      since_start = 0;
      run_pulses  = 0;
    end else begin
      since_start = since_start + 1;
    end
    if (retire || halt) begin
      // first pulse two cycles after start, then one per cycle
      check_value($sformatf("cycles from start to pulse %0d", pulses + 1),
                  2 + run_pulses, since_start);
      run_pulses = run_pulses + 1;
    end
    if (retire) begin
      pulses = pulses + 1;
      if (exp_kind.size() == 0 || exp_kind[0] != K_RETIRE) begin
        stop_on_failure($sformatf("retire pulse %0d came where none was expected", pulses));
      end else begin
        check_value($sformatf("retire rd, pulse %0d", pulses), exp_a[0], {59'b0, retire_rd});
        check_value($sformatf("retire data, pulse %0d", pulses), exp_b[0], retire_data);
        void'(exp_kind.pop_front());
        void'(exp_a.pop_front());
        void'(exp_b.pop_front());
      end
    end
    if (halt) begin
      pulses = pulses + 1;
      if (exp_kind.size() == 0 || exp_kind[0] != K_HALT) begin
        stop_on_failure($sformatf("halt pulse %0d came where none was expected", pulses));
      end else begin
        check_value($sformatf("halt flag, pulse %0d", pulses), exp_a[0], {63'b0, halt_illegal});
        void'(exp_kind.pop_front());
        void'(exp_a.pop_front());
        void'(exp_b.pop_front());
        halt_seen = 1'b1;
      end
    end
  end

  initial begin
    int          r;
    int          n_idle;
    logic [63:0] kind;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] prev_kind;
    void'($urandom(32'h7f8f));
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    dbg_addr  = '0;
    $readmemh("sim/rv_core_patterns.txt", pat);
    n_rec = 0;
    while (n_rec < MAX_REC && pat[3*n_rec] != K_END) begin
      n_rec++;
    end
    // end record counts too
    limit = CYC_PER_REC * (n_rec + 1);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    prev_kind = K_END;
    for (r = 0; r < n_rec; r++) begin
      kind = pat[3*r];
      a    = pat[3*r+1];
      b    = pat[3*r+2];
      if (kind == K_LOAD) begin
        // idle gap ahead of every later program
        if (prev_kind != K_LOAD && prev_kind != K_END) begin
          n_idle = $urandom_range(3, 0);
          repeat (n_idle) @(posedge clk);
        end
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= a[`IMEM_AW-1:0];
        load_data <= b[31:0];
      end else if (kind == K_START) begin
        @(posedge clk);
        load_en   <= 1'b0;
        start     <= 1'b1;
        halt_seen = 1'b0;
        @(posedge clk);
        start <= 1'b0;
      end else if (kind == K_RETIRE || kind == K_HALT) begin
        exp_kind.push_back(kind);
        exp_a.push_back(a);
        exp_b.push_back(b);
        // program done once its halt is seen
        if (kind == K_HALT) begin
          wait (halt_seen);
        end
      end else if (kind == K_DEBUG) begin
        @(posedge clk);
        dbg_addr <= a[4:0];
        @(negedge clk);
        check_value($sformatf("debug read x%0d", a[4:0]), b, dbg_data);
      end else begin
        stop_on_failure($sformatf("pattern record %0d has unknown kind %h", r, kind));
      end
      prev_kind = kind;
    end
    // room for a stray pulse after the last halt
    repeat (4) @(posedge clk);
    if (exp_kind.size() != 0) begin
      stop_on_failure($sformatf("%0d expected pulses never came", exp_kind.size()));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== rv_core.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_imem.sv
verilog/rv_ctrl.sv
verilog/rv_idu.sv
verilog/rv_regfile.sv
verilog/rv_exu.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rv_core testbench with Verilator, run it, and judge by the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_rv_core > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0

// ==== sim/rv_core_patterns.txt ====
// one record per line: kind arg1 arg2, all hex
// kind 1 load: word address, instruction | 2 start | 3 retire: rd, data
// kind 4 halt: illegal flag | 5 debug read: register, value | 0 end
1 0 00500093  // addi x1, x0, 5
1 1 ffd08113  // addi x2, x1, -3
1 2 80010193  // addi x3, x2, -2048
1 3 12345217  // auipc x4, 0x12345 at pc 12
1 4 80000297  // auipc x5, 0x80000 at pc 16
1 5 06408013  // addi x0, x1, 100
1 6 00001017  // auipc x0, 1
1 7 00100073  // ebreak
1 8 00100313  // addi x6, x0, 1, never reached
2 0 0
3 1 5
3 2 2
3 3 fffffffffffff802
3 4 1234500c
3 5 ffffffff80000010
3 0 0
3 0 0
4 0 0
5 0 0
5 1 5
5 2 2
5 3 fffffffffffff802
5 4 1234500c
5 5 ffffffff80000010
5 6 0
1 0 fffff397  // auipc x7, 0xfffff at pc 0
1 1 7ffff317  // auipc x6, 0x7ffff at pc 4
1 2 7ff08413  // addi x8, x1, 2047, x1 kept from first run
1 3 00118493  // addi x9, x3, 1
1 4 00000033  // add, not decoded
2 0 0
3 7 fffffffffffff000
3 6 7ffff004
3 8 804
3 9 fffffffffffff803
4 1 0
5 7 fffffffffffff000
5 6 7ffff004
5 8 804
5 9 fffffffffffff803
5 1 5
5 5 ffffffff80000010
5 0 0
0 0 0
